/* include/ctl_macros.svh */
////////////////////
// transducer control block
// register map, field widths, table depth and version word
////////////////////
`ifndef CTL_MACROS_SVH
`define CTL_MACROS_SVH

`define CTL_ADDR_W              9
`define CTL_DATA_W              16
`define CTL_STEP_W              13
`define CTL_CYCLE_DEPTH         8
`define CTL_VERSION_WORD        16'h0082

// register addresses
`define CTL_ADDR_CTL            9'h000
`define CTL_ADDR_INFO           9'h001
`define CTL_ADDR_SYNC_TICKS     9'h010
`define CTL_ADDR_SYNC_TIME0     9'h011
`define CTL_ADDR_SYNC_TIME1     9'h012
`define CTL_ADDR_SYNC_TIME2     9'h013
`define CTL_ADDR_SYNC_TIME3     9'h014
`define CTL_ADDR_MOD_CYCLE      9'h020
`define CTL_ADDR_MOD_DIV0       9'h021
`define CTL_ADDR_MOD_DIV1       9'h022
`define CTL_ADDR_SIL_CYCLE      9'h030
`define CTL_ADDR_SIL_STEP       9'h031
`define CTL_ADDR_STM_CYCLE      9'h040
`define CTL_ADDR_STM_DIV0       9'h041
`define CTL_ADDR_STM_DIV1       9'h042
`define CTL_ADDR_SOUND0         9'h043
`define CTL_ADDR_SOUND1         9'h044
`define CTL_ADDR_VERSION        9'h0ff
`define CTL_ADDR_CYCLE_BASE     9'h100

// control word bits
`define CTL_BIT_LOAD_LO         0
`define CTL_BIT_LOAD_HI         1
`define CTL_BIT_FORCE_FAN       4
`define CTL_BIT_OP_MODE         5
`define CTL_BIT_GAIN_MODE       6
`define CTL_BIT_SYNC            8
`define CTL_BIT_WDT_RST         15

`endif

/* hdl/ctl_pkg.sv */
////////////////////
// transducer control types
// host bus, RAM port and parameter bundles
////////////////////
`default_nettype none

`include "ctl_macros.svh"

package ctl_pkg;

        typedef struct packed {
                logic                   en;
                logic                   we;
                logic [`CTL_ADDR_W-1:0] addr;
                logic [`CTL_DATA_W-1:0] wdata;
        } host_req_t;

        typedef logic [`CTL_DATA_W-1:0] ctl_word_t;

        typedef struct packed {
                logic [15:0]            mod_cycle;
                logic [31:0]            mod_div;
                logic [15:0]            sil_cycle;
                logic [`CTL_STEP_W-1:0] sil_step;
                logic [15:0]            stm_cycle;
                logic [31:0]            stm_div;
                logic [31:0]            sound_speed;
        } run_params_t;

        typedef struct packed {
                logic [63:0]            sync_time;
                logic [15:0]            sync_ticks;
                logic [`CTL_CYCLE_DEPTH-1:0][`CTL_STEP_W-1:0] cycle_tab;
        } sync_params_t;

        // sequencer side, always enabled
        typedef struct packed {
                logic                   we;
                logic [`CTL_ADDR_W-1:0] addr;
                logic [`CTL_DATA_W-1:0] wdata;
        } ram_port_t;

endpackage

`default_nettype wire

/* hdl/ctl_reg_ram.sv */
////////////////////
// register RAM
// dual port, host side and sequencer side,
// two cycle read latency on both ports
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ctl_macros.svh"

module ctl_reg_ram (
        input  wire                     CLK,
        input  wire ctl_pkg::host_req_t host,
        output logic [`CTL_DATA_W-1:0]  host_rdata,
        input  wire ctl_pkg::ram_port_t seq,
        output logic [`CTL_DATA_W-1:0]  seq_rdata
);

        localparam int DEPTH = 1 << `CTL_ADDR_W;

        logic [`CTL_DATA_W-1:0] mem [0:DEPTH-1];
        logic [`CTL_ADDR_W-1:0] host_addr_q;
        logic [`CTL_ADDR_W-1:0] seq_addr_q;

        always_ff @(posedge CLK) begin
                if (seq.we)
                        mem[seq.addr] <= seq.wdata;
                if (host.en && host.we)
                        mem[host.addr] <= host.wdata;  // later write, host wins
        end

        always_ff @(posedge CLK) begin
                if (host.en && !host.we)
                        host_addr_q <= host.addr;
                host_rdata  <= mem[host_addr_q];
                seq_addr_q  <= seq.addr;
                seq_rdata   <= mem[seq_addr_q];
        end

        a_host_addr: assert property (@(posedge CLK)
                host.en && host.we |-> !$isunknown(host.addr) && host.addr < DEPTH);

        a_seq_addr: assert property (@(posedge CLK)
                seq.we |-> !$isunknown(seq.addr) && seq.addr < DEPTH);

endmodule

`default_nettype wire

/* hdl/ctl_sequencer.sv */
////////////////////
// control sequencer
// writes the version word, polls the run registers
// in a pipelined loop and fetches the sync set
// when the host raises the sync bit
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ctl_macros.svh"

module ctl_sequencer (
        input  wire                     CLK,
        input  wire                     reset,
        output ctl_pkg::ram_port_t      ram,
        input  wire [`CTL_DATA_W-1:0]   rdata,
        input  wire                     thermo_sync,
        output ctl_pkg::ctl_word_t      ctl,
        output ctl_pkg::run_params_t    run,
        output ctl_pkg::sync_params_t   sync,
        output logic                    sync_done
);

        localparam int DEPTH = `CTL_CYCLE_DEPTH;
        localparam int CNT_W = $clog2(DEPTH) + 1;

        typedef enum logic [4:0] {
                init_ver, init_req_ctl, init_wait, init_req_mod,
                run_ctl, run_gap, run_mod_cycle, run_mod_div0, run_mod_div1,
                run_sil_cycle, run_sil_step, run_stm_cycle, run_stm_div0,
                run_stm_div1, run_sound0, run_sound1,
                sync_clr, sync_t0, sync_t1, sync_t2, sync_t3,
                sync_c0, sync_c1, sync_c2, sync_tab
        } state_t;

        state_t           state;
        logic [CNT_W-1:0] cnt;

        // each state captures the word requested three states back
        always_ff @(posedge CLK) begin
                if (reset) begin
                        state     <= init_ver;
                        ram.we    <= 1'b0;
                        sync_done <= 1'b0;
                        ctl       <= '0;
                        run       <= '0;
                        sync      <= '0;
                end else begin
                        sync_done <= 1'b0;
                        case (state)
                        ////////////////////
                        init_ver: begin
                                ram.we    <= 1'b1;
                                ram.addr  <= `CTL_ADDR_VERSION;
                                ram.wdata <= `CTL_VERSION_WORD;
                                state     <= init_req_ctl;
                        end
                        init_req_ctl: begin
                                ram.we   <= 1'b0;
                                ram.addr <= `CTL_ADDR_CTL;
                                state    <= init_wait;
                        end
                        init_wait: state <= init_req_mod;
                        init_req_mod: begin
                                ram.addr <= `CTL_ADDR_MOD_CYCLE;  // lines up with run_sound1
                                state    <= run_ctl;
                        end
                        ////////////////////
                        run_ctl: begin
                                ctl <= rdata;
                                if (rdata[`CTL_BIT_SYNC]) begin
                                        ram.we    <= 1'b1;
                                        ram.addr  <= `CTL_ADDR_CTL;
                                        ram.wdata <= rdata;
                                        ram.wdata[`CTL_BIT_SYNC] <= 1'b0;
                                        state     <= sync_clr;
                                end else begin
                                        ram.addr <= `CTL_ADDR_MOD_DIV0;
                                        state    <= run_gap;
                                end
                        end
                        run_gap: begin
                                ram.addr <= `CTL_ADDR_MOD_DIV1;  // info write slot
                                state    <= run_mod_cycle;
                        end
                        run_mod_cycle: begin
                                run.mod_cycle <= rdata;
                                ram.addr      <= `CTL_ADDR_SIL_CYCLE;
                                state         <= run_mod_div0;
                        end
                        run_mod_div0: begin
                                run.mod_div[15:0] <= rdata;
                                ram.addr          <= `CTL_ADDR_SIL_STEP;
                                state             <= run_mod_div1;
                        end
                        run_mod_div1: begin
                                run.mod_div[31:16] <= rdata;
                                ram.addr           <= `CTL_ADDR_STM_CYCLE;
                                state              <= run_sil_cycle;
                        end
                        run_sil_cycle: begin
                                run.sil_cycle <= rdata;
                                ram.addr      <= `CTL_ADDR_STM_DIV0;
                                state         <= run_sil_step;
                        end
                        run_sil_step: begin
                                run.sil_step <= rdata[`CTL_STEP_W-1:0];
                                ram.addr     <= `CTL_ADDR_STM_DIV1;
                                state        <= run_stm_cycle;
                        end
                        run_stm_cycle: begin
                                run.stm_cycle <= rdata;
                                ram.addr      <= `CTL_ADDR_SOUND0;
                                state         <= run_stm_div0;
                        end
                        run_stm_div0: begin
                                run.stm_div[15:0] <= rdata;
                                ram.addr          <= `CTL_ADDR_SOUND1;
                                state             <= run_stm_div1;
                        end
                        run_stm_div1: begin
                                run.stm_div[31:16] <= rdata;
                                ram.addr           <= `CTL_ADDR_CTL;
                                state              <= run_sound0;
                        end
                        run_sound0: begin
                                run.sound_speed[15:0] <= rdata;
                                ram.we    <= 1'b1;  // status word
                                ram.addr  <= `CTL_ADDR_INFO;
                                ram.wdata <= {{(`CTL_DATA_W-1){1'b0}}, thermo_sync};
                                state     <= run_sound1;
                        end
                        run_sound1: begin
                                run.sound_speed[31:16] <= rdata;
                                ram.we   <= 1'b0;
                                ram.addr <= `CTL_ADDR_MOD_CYCLE;
                                state    <= run_ctl;
                        end
                        ////////////////////
                        sync_clr: begin
                                ram.we   <= 1'b0;
                                ram.addr <= `CTL_ADDR_SYNC_TICKS;
                                state    <= sync_t0;
                        end
                        sync_t0: begin
                                ram.addr <= `CTL_ADDR_SYNC_TIME0;
                                state    <= sync_t1;
                        end
                        sync_t1: begin
                                ram.addr <= `CTL_ADDR_SYNC_TIME1;
                                state    <= sync_t2;
                        end
                        sync_t2: begin
                                sync.sync_ticks <= rdata;
                                ram.addr        <= `CTL_ADDR_SYNC_TIME2;
                                state           <= sync_t3;
                        end
                        sync_t3: begin
                                sync.sync_time[15:0] <= rdata;
                                ram.addr             <= `CTL_ADDR_SYNC_TIME3;
                                state                <= sync_c0;
                        end
                        sync_c0: begin
                                sync.sync_time[31:16] <= rdata;
                                ram.addr              <= `CTL_ADDR_CYCLE_BASE;
                                state                 <= sync_c1;
                        end
                        sync_c1: begin
                                sync.sync_time[47:32] <= rdata;
                                ram.addr              <= ram.addr + 1'b1;
                                state                 <= sync_c2;
                        end
                        sync_c2: begin
                                sync.sync_time[63:48] <= rdata;
                                ram.addr              <= ram.addr + 1'b1;
                                cnt                   <= '0;
                                state                 <= sync_tab;
                        end
                        sync_tab: begin
                                sync.cycle_tab[cnt] <= rdata[`CTL_STEP_W-1:0];
                                if (cnt == CNT_W'(DEPTH - 1)) begin
                                        sync_done <= 1'b1;
                                        state     <= init_req_ctl;  // recapture ctl
                                end else begin
                                        ram.addr <= ram.addr + 1'b1;
                                        cnt      <= cnt + 1'b1;
                                end
                        end
                        default: state <= init_ver;
                        endcase
                end
        end

        a_done_pulse: assert property (@(posedge CLK) disable iff (reset)
                sync_done |=> !sync_done);

        a_tab_cnt: assert property (@(posedge CLK) disable iff (reset)
                state == sync_tab |-> cnt < CNT_W'(DEPTH));

endmodule

`default_nettype wire

/* hdl/ctl_out_stage.sv */
////////////////////
// output stage
// thermo synchronizer, control word decode,
// held parameters and sync strobe
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ctl_macros.svh"

module ctl_out_stage (
        input  wire                         CLK,
        input  wire                         reset,
        input  wire                         thermo,
        output logic                        thermo_sync,
        input  wire ctl_pkg::ctl_word_t     ctl,
        input  wire ctl_pkg::run_params_t   run,
        input  wire ctl_pkg::sync_params_t  sync,
        input  wire                         sync_done,
        output logic [1:0]                  load_mode,
        output logic                        force_fan,
        output logic                        op_mode,
        output logic                        gain_mode,
        output logic                        wdt_rst,
        output ctl_pkg::run_params_t        run_out,
        output ctl_pkg::sync_params_t       sync_out,
        output logic                        sync_set
);

        logic thermo_meta;

        always_ff @(posedge CLK) begin
                if (reset) begin
                        thermo_meta <= 1'b0;
                        thermo_sync <= 1'b0;
                        load_mode   <= 2'b00;
                        force_fan   <= 1'b0;
                        op_mode     <= 1'b0;
                        gain_mode   <= 1'b0;
                        wdt_rst     <= 1'b0;
                        run_out     <= '0;
                        sync_out    <= '0;
                        sync_set    <= 1'b0;
                end else begin
                        thermo_meta <= thermo;
                        thermo_sync <= thermo_meta;
                        load_mode   <= ctl[`CTL_BIT_LOAD_HI:`CTL_BIT_LOAD_LO];
                        force_fan   <= ctl[`CTL_BIT_FORCE_FAN];
                        op_mode     <= ctl[`CTL_BIT_OP_MODE];
                        gain_mode   <= ctl[`CTL_BIT_GAIN_MODE];
                        wdt_rst     <= ctl[`CTL_BIT_WDT_RST];
                        run_out     <= run;
                        sync_set    <= sync_done;
                        if (sync_done)
                                sync_out <= sync;  // new set shows with sync_set
                end
        end

        a_sync_hold: assert property (@(posedge CLK) disable iff (reset)
                !sync_set |-> $stable(sync_out));

endmodule

`default_nettype wire

/* hdl/ctl_top.sv */
////////////////////
// transducer control top
// register RAM, sequencer and output stage
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ctl_macros.svh"

module ctl_top (
        input  wire                         CLK,
        input  wire                         reset,
        input  wire ctl_pkg::host_req_t     host,
        output wire [`CTL_DATA_W-1:0]       host_rdata,
        input  wire                         thermo,
        output wire [1:0]                   load_mode,
        output wire                         force_fan,
        output wire                         op_mode,
        output wire                         gain_mode,
        output wire                         wdt_rst,
        output wire ctl_pkg::run_params_t   run_out,
        output wire ctl_pkg::sync_params_t  sync_out,
        output wire                         sync_set
);

        ctl_pkg::ram_port_t     ram;
        logic [`CTL_DATA_W-1:0] seq_rdata;
        logic                   thermo_sync;
        ctl_pkg::ctl_word_t     ctl;
        ctl_pkg::run_params_t   run;
        ctl_pkg::sync_params_t  sync;
        logic                   sync_done;

        ctl_reg_ram ram_i (
                .CLK        (CLK),
                .host       (host),
                .host_rdata (host_rdata),
                .seq        (ram),
                .seq_rdata  (seq_rdata)
        );

        ctl_sequencer seq_i (
                .CLK         (CLK),
                .reset       (reset),
                .ram         (ram),
                .rdata       (seq_rdata),
                .thermo_sync (thermo_sync),
                .ctl         (ctl),
                .run         (run),
                .sync        (sync),
                .sync_done   (sync_done)
        );

        ctl_out_stage out_i (
                .CLK         (CLK),
                .reset       (reset),
                .thermo      (thermo),
                .thermo_sync (thermo_sync),
                .ctl         (ctl),
                .run         (run),
                .sync        (sync),
                .sync_done   (sync_done),
                .load_mode   (load_mode),
                .force_fan   (force_fan),
                .op_mode     (op_mode),
                .gain_mode   (gain_mode),
                .wdt_rst     (wdt_rst),
                .run_out     (run_out),
                .sync_out    (sync_out),
                .sync_set    (sync_set)
        );

endmodule

`default_nettype wire

/* dv/ctl_tb.sv */
////////////////////
// testbench for the transducer control top
// host writes and reads, run parameters, mode decode,
// status word and the sync fetch
////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "ctl_macros.svh"

module ctl_tb;

        localparam int AW    = `CTL_ADDR_W;
        localparam int DEPTH = `CTL_CYCLE_DEPTH;

        logic                   CLK;
        logic                   reset;
        ctl_pkg::host_req_t     host;
        logic                   thermo;
        logic [`CTL_DATA_W-1:0] host_rdata;
        logic [1:0]             load_mode;
        logic                   force_fan;
        logic                   op_mode;
        logic                   gain_mode;
        logic                   wdt_rst;
        ctl_pkg::run_params_t   run_out;
        ctl_pkg::sync_params_t  sync_out;
        logic                   sync_set;
        logic [5:0]             modes;

        assign modes = {load_mode, force_fan, op_mode, gain_mode, wdt_rst};

        ctl_top dut_i (
                .CLK        (CLK),
                .reset      (reset),
                .host       (host),
                .host_rdata (host_rdata),
                .thermo     (thermo),
                .load_mode  (load_mode),
                .force_fan  (force_fan),
                .op_mode    (op_mode),
                .gain_mode  (gain_mode),
                .wdt_rst    (wdt_rst),
                .run_out    (run_out),
                .sync_out   (sync_out),
                .sync_set   (sync_set)
        );

        always #5 CLK = ~CLK;

        ////////////////////
        task automatic stop_run();
                $display("TEST FAILED");
                $fatal(1, "stopped at first error");
        endtask

        task automatic report_problem(input string what);
                $display("ERROR at %0t ns: %s", $time, what);
                stop_run();
        endtask

        task automatic report_mismatch(input string name, input logic [255:0] expected,
                                       input logic [255:0] actual);
                $display("FAILED at %0t ns: %s expected %0h actual %0h",
                         $time, name, expected, actual);
                stop_run();
        endtask

        task automatic check_value(input string name, input logic [255:0] expected,
                                   input logic [255:0] actual);
                assert (actual === expected)
                else report_mismatch(name, expected, actual);
        endtask

        // all host tasks start and end 1 ns after a rising edge
        task automatic host_write(input logic [AW-1:0] addr, input logic [15:0] data);
                host.en    = 1'b1;
                host.we    = 1'b1;
                host.addr  = addr;
                host.wdata = data;
                @(posedge CLK);
                #1;
                host.en = 1'b0;
                host.we = 1'b0;
        endtask

        task automatic host_read(input logic [AW-1:0] addr, output logic [15:0] data);
                host.en   = 1'b1;
                host.we   = 1'b0;
                host.addr = addr;
                @(posedge CLK);
                #1;
                host.en = 1'b0;
                @(posedge CLK);
                @(posedge CLK);  // two cycles of read latency
                #1;
                data = host_rdata;
        endtask

        function automatic logic [5:0] decode_ctl(input logic [15:0] w);
                return {w[`CTL_BIT_LOAD_HI], w[`CTL_BIT_LOAD_LO], w[`CTL_BIT_FORCE_FAN],
                        w[`CTL_BIT_OP_MODE], w[`CTL_BIT_GAIN_MODE], w[`CTL_BIT_WDT_RST]};
        endfunction

        task automatic wait_run(input ctl_pkg::run_params_t expected, input int limit);
                int n;
                n = 0;
                while (run_out !== expected && n < limit) begin
                        @(posedge CLK);
                        #1;
                        n++;
                end
                check_value("run_out", 256'(expected), 256'(run_out));
        endtask

        task automatic wait_modes(input logic [5:0] expected, input int limit);
                int n;
                n = 0;
                while (modes !== expected && n < limit) begin
                        @(posedge CLK);
                        #1;
                        n++;
                end
                check_value("mode outputs", 256'(expected), 256'(modes));
        endtask

        ////////////////////
        a_set_pulse: assert property (@(posedge CLK) disable iff (reset)
                sync_set |=> !sync_set)
                else report_problem("sync_set stayed high for more than one cycle");

        a_reset_idle: assert property (@(posedge CLK)
                reset |=> !sync_set && modes == 6'h00)
                else report_problem("outputs not idle after a reset cycle");

        initial begin
                logic [15:0]           w [10];
                logic [15:0]           rd;
                logic [15:0]           ctl_word;
                logic [15:0]           v;
                logic                  lvl;
                ctl_pkg::run_params_t  run_exp;
                ctl_pkg::sync_params_t sync_exp;
                int                    pulses;

                void'($urandom(91));
                CLK    = 1'b0;
                reset  = 1'b1;
                host   = '0;
                thermo = 1'b0;
                @(posedge CLK);
                #1;
                host_write(`CTL_ADDR_CTL, 16'h0000);  // RAM has no reset
                repeat (3) @(posedge CLK);
                #1;
                reset = 1'b0;

                // idle after reset, version word
                check_value("sync_set", '0, 256'(sync_set));
                check_value("mode outputs", '0, 256'(modes));
                check_value("run_out", '0, 256'(run_out));
                repeat (6) @(posedge CLK);
                #1;
                host_read(`CTL_ADDR_VERSION, rd);
                check_value("host_rdata version", 256'(`CTL_VERSION_WORD), 256'(rd));

                // run parameters, two rounds
                for (int round = 0; round < 2; round++) begin
                        for (int i = 0; i < 10; i++)
                                w[i] = 16'($urandom);
                        host_write(`CTL_ADDR_MOD_CYCLE, w[0]);
                        host_write(`CTL_ADDR_MOD_DIV0, w[1]);
                        host_write(`CTL_ADDR_MOD_DIV1, w[2]);
                        host_write(`CTL_ADDR_SIL_CYCLE, w[3]);
                        host_write(`CTL_ADDR_SIL_STEP, w[4]);
                        host_write(`CTL_ADDR_STM_CYCLE, w[5]);
                        host_write(`CTL_ADDR_STM_DIV0, w[6]);
                        host_write(`CTL_ADDR_STM_DIV1, w[7]);
                        host_write(`CTL_ADDR_SOUND0, w[8]);
                        host_write(`CTL_ADDR_SOUND1, w[9]);
                        run_exp.mod_cycle   = w[0];
                        run_exp.mod_div     = {w[2], w[1]};  // low word first
                        run_exp.sil_cycle   = w[3];
                        run_exp.sil_step    = w[4][`CTL_STEP_W-1:0];
                        run_exp.stm_cycle   = w[5];
                        run_exp.stm_div     = {w[7], w[6]};
                        run_exp.sound_speed = {w[9], w[8]};
                        wait_run(run_exp, 26);
                end

                // control word decode
                for (int i = 0; i < 4; i++) begin
                        ctl_word = 16'($urandom);
                        ctl_word[`CTL_BIT_SYNC] = 1'b0;
                        host_write(`CTL_ADDR_CTL, ctl_word);
                        wait_modes(decode_ctl(ctl_word), 26);
                end

                // status word, both thermo levels
                lvl = 1'($urandom);
                for (int i = 0; i < 2; i++) begin
                        thermo = lvl;
                        repeat (30) @(posedge CLK);
                        #1;
                        host_read(`CTL_ADDR_INFO, rd);
                        check_value("host_rdata info", 256'(16'(lvl)), 256'(rd));
                        lvl = ~lvl;
                end

                ////////////////////
                // sync fetch
                sync_exp.sync_ticks = 16'($urandom);
                host_write(`CTL_ADDR_SYNC_TICKS, sync_exp.sync_ticks);
                for (int i = 0; i < 4; i++) begin
                        w[i] = 16'($urandom);
                        host_write(AW'(`CTL_ADDR_SYNC_TIME0 + i), w[i]);
                end
                sync_exp.sync_time = {w[3], w[2], w[1], w[0]};
                for (int i = 0; i < DEPTH; i++) begin
                        v = 16'($urandom);
                        host_write(AW'(`CTL_ADDR_CYCLE_BASE + i), v);
                        sync_exp.cycle_tab[i] = v[`CTL_STEP_W-1:0];
                end
                ctl_word = 16'($urandom);
                ctl_word[`CTL_BIT_SYNC] = 1'b1;
                host_write(`CTL_ADDR_CTL, ctl_word);

                pulses = 0;
                for (int n = 0; n < 60; n++) begin
                        @(posedge CLK);
                        #1;
                        if (sync_set) begin
                                pulses++;
                                check_value("sync_out", 256'(sync_exp), 256'(sync_out));
                        end
                end
                if (pulses == 0)
                        report_problem("sync_set did not pulse within 60 cycles");
                else
                        check_value("sync_set pulse count", 256'(1), 256'(pulses));

                ctl_word[`CTL_BIT_SYNC] = 1'b0;  // cleared by the sequencer
                host_read(`CTL_ADDR_CTL, rd);
                check_value("host_rdata ctl", 256'(ctl_word), 256'(rd));

                $display("TEST OK");
                $finish;
        end

endmodule

`default_nettype wire

/* tb.f */
+incdir+include
hdl/ctl_pkg.sv
hdl/ctl_reg_ram.sv
hdl/ctl_sequencer.sv
hdl/ctl_out_stage.sv
hdl/ctl_top.sv
dv/ctl_tb.sv

/* Makefile */
# Verilator build and run for the transducer control block

VERILATOR  ?= verilator
TOP        ?= ctl_tb
FILELIST   ?= tb.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv dv/*.sv include/*.svh)

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: $(BIN)
	-$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "simulation ended without a result"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
